// File: Bender.yml
package:
  name: sdram_ctrl

sources:
  - hw/sdram_pkg.sv
  - hw/sdram_timer.sv
  - hw/sdram_fsm.sv
  - hw/sdram_datapath.sv
  - hw/sdram_top.sv
  - target: simulation
    files:
      - sim/sdram_model.sv
      - sim/tb_sdram.sv

// File: all.f
hw/sdram_pkg.sv
hw/sdram_timer.sv
hw/sdram_fsm.sv
hw/sdram_datapath.sv
hw/sdram_top.sv
sim/sdram_model.sv
sim/tb_sdram.sv

// File: hw/sdram_datapath.sv
//===========================================================
// dq bus side: write word pacing with output enable, read
// capture after the cas latency, and end-of-burst detect.
//===========================================================
`timescale 1ns/1ns
module sdram_datapath (
	input  logic                   osc,
	input  logic                   rst_n,
	input  sdram_pkg::sdram_mode_u mode,
	input  logic                   burst_wr,
	input  logic                   burst_rd,
	input  logic [15:0]            wr_data,
	output logic                   wr_next,
	output logic [15:0]            rd_data,
	output logic                   rd_valid,
	output logic                   burst_end,
	inout  wire  [15:0]            dq
);
	logic [2:0] last_idx; // burst length minus one.
	logic [2:0] left;     // words still to pace.
	logic       rd_dir;
	logic       start;
	logic       go;
	logic       go_rd;
	logic       go_last;
	logic       dq_oe;
	logic       wr_end;
	logic [3:0] cap_sh;   // read strobe delayed by 1..4 cycles.
	logic [3:0] end_sh;

	assign last_idx = 3'((4'd1 << mode.f.bl[1:0]) - 4'd1);
	assign start    = burst_wr || burst_rd;
	assign go       = start || (left != 3'd0);
	assign go_rd    = burst_rd || (rd_dir && left != 3'd0);
	assign go_last  = go && (start ? (last_idx == 3'd0) : (left == 3'd1));
	assign wr_next  = go && !go_rd;

	// word arrives one cycle after its wr_next pulse.
	assign dq = dq_oe ? wr_data : {16{1'bz}};

	// read burst ends on its last capture, cl + 1 cycles on.
	assign burst_end = wr_end || end_sh[mode.f.cl[1:0]];

	always_ff @(posedge osc) begin
		if (!rst_n) begin
			left     <= 3'd0;
			rd_dir   <= 1'b0;
			dq_oe    <= 1'b0;
			wr_end   <= 1'b0;
			cap_sh   <= 4'b0000;
			end_sh   <= 4'b0000;
			rd_valid <= 1'b0;
		end else begin
			if (start) begin
				left   <= last_idx;
				rd_dir <= burst_rd;
			end else if (left != 3'd0) begin
				left <= left - 3'd1;
			end
			dq_oe    <= wr_next;
			wr_end   <= go_last && !go_rd;
			cap_sh   <= {cap_sh[2:0], go_rd};
			end_sh   <= {end_sh[2:0], go_last && go_rd};
			rd_valid <= cap_sh[mode.f.cl[1:0]];
		end
	end

	always_ff @(posedge osc) begin
		if (cap_sh[mode.f.cl[1:0]])
			rd_data <= dq;
	end

endmodule

// File: hw/sdram_fsm.sv
//===========================================================
// controller FSM: power-up sequence, request accept, refresh
// and the registered command, bank, address and dqm pins.
//===========================================================
`timescale 1ns/1ns
module sdram_fsm (
	input  logic                   osc,
	input  logic                   rst_n,
	input  sdram_pkg::sdram_mode_u mode,
	input  logic                   wr_req,
	input  logic                   rd_req,
	input  sdram_pkg::sdram_req_t  req,
	output logic                   ready,
	output sdram_pkg::sdram_pins_t pins,
	output logic                   timer_load,
	output sdram_pkg::sdram_wait_e timer_sel,
	input  logic                   timer_done,
	input  logic                   refresh_due,
	output logic                   refresh_ack,
	output logic                   burst_wr,
	output logic                   burst_rd,
	input  logic                   burst_end
);
	typedef enum logic [3:0] {
		init_wait, init_pre, init_ref, init_mode, idle,
		activate, rw_cmd, burst, precharge, refresh
	} state_e;

	state_e                state;
	sdram_pkg::sdram_req_t req_q;
	logic                  is_rd;
	logic                  pend;     // request taken while a refresh runs.
	logic                  ref_step; // auto_refresh already issued.

	// pacing starts one cycle ahead of the write/read on the pins.
	assign burst_wr = (state == rw_cmd) && timer_done && !is_rd;
	assign burst_rd = (state == rw_cmd) && timer_done && is_rd;

	always_ff @(posedge osc) begin
		if (state == idle && (wr_req || rd_req))
			req_q <= req;
	end

	always_ff @(posedge osc) begin
		if (!rst_n) begin
			state       <= init_wait;
			pins.cke    <= 1'b0;
			pins.cmd    <= sdram_pkg::nop;
			pins.ba     <= 2'b00;
			pins.addr   <= 12'h000;
			pins.dqm    <= 2'b11;
			ready       <= 1'b0;
			timer_load  <= 1'b1; // power-up wait starts right away.
			timer_sel   <= sdram_pkg::w_init;
			refresh_ack <= 1'b0;
			is_rd       <= 1'b0;
			pend        <= 1'b0;
			ref_step    <= 1'b0;
		end else begin
			pins.cke    <= 1'b1;
			pins.cmd    <= sdram_pkg::nop;
			timer_load  <= 1'b0;
			refresh_ack <= 1'b0;
			case (state)
				init_wait: if (timer_done) begin
					pins.cmd   <= sdram_pkg::precharge;
					pins.addr  <= 12'h400; // all banks.
					timer_load <= 1'b1;
					timer_sel  <= sdram_pkg::w_rp;
					state      <= init_pre;
				end
				init_pre: if (timer_done) begin
					pins.cmd   <= sdram_pkg::auto_refresh;
					timer_load <= 1'b1;
					timer_sel  <= sdram_pkg::w_rfc;
					ref_step   <= 1'b0;
					state      <= init_ref;
				end
				init_ref: if (timer_done) begin
					timer_load <= 1'b1;
					if (!ref_step) begin
						pins.cmd  <= sdram_pkg::auto_refresh; // second one.
						timer_sel <= sdram_pkg::w_rfc;
						ref_step  <= 1'b1;
					end else begin
						pins.cmd  <= sdram_pkg::load_mode;
						pins.ba   <= 2'b00;
						pins.addr <= mode.raw;
						timer_sel <= sdram_pkg::w_mrd;
						state     <= init_mode;
					end
				end
				init_mode: if (timer_done) begin
					ready <= 1'b1;
					state <= idle;
				end
				idle: begin
					if (wr_req || rd_req) begin
						is_rd <= !wr_req; // write wins a tie.
						ready <= 1'b0;
					end
					if (refresh_due) begin
						pins.cmd    <= sdram_pkg::precharge;
						pins.addr   <= 12'h400;
						timer_load  <= 1'b1;
						timer_sel   <= sdram_pkg::w_rp;
						refresh_ack <= 1'b1;
						ready       <= 1'b0;
						ref_step    <= 1'b0;
						pend        <= wr_req || rd_req;
						state       <= refresh;
					end else if (wr_req || rd_req) begin
						pins.cmd   <= sdram_pkg::active;
						pins.ba    <= req.ba;
						pins.addr  <= req.row;
						timer_load <= 1'b1;
						timer_sel  <= sdram_pkg::w_rcd;
						state      <= activate;
					end
				end
				refresh: if (timer_done) begin
					if (!ref_step) begin
						pins.cmd   <= sdram_pkg::auto_refresh;
						timer_load <= 1'b1;
						timer_sel  <= sdram_pkg::w_rfc;
						ref_step   <= 1'b1;
					end else if (pend) begin
						pins.cmd   <= sdram_pkg::active; // held request.
						pins.ba    <= req_q.ba;
						pins.addr  <= req_q.row;
						timer_load <= 1'b1;
						timer_sel  <= sdram_pkg::w_rcd;
						pend       <= 1'b0;
						state      <= activate;
					end else begin
						ready <= 1'b1;
						state <= idle;
					end
				end
				activate: state <= rw_cmd; // active on the pins.
				rw_cmd: if (timer_done) begin
					pins.cmd  <= is_rd ? sdram_pkg::read : sdram_pkg::write;
					pins.ba   <= req_q.ba;
					pins.addr <= {4'b0000, req_q.col}; // a10 low, no auto precharge.
					pins.dqm  <= 2'b00;
					state     <= burst;
				end
				burst: if (burst_end) begin
					pins.cmd   <= sdram_pkg::precharge;
					pins.ba    <= req_q.ba;
					pins.addr  <= 12'h000;
					pins.dqm   <= 2'b11;
					timer_load <= 1'b1;
					timer_sel  <= sdram_pkg::w_rp;
					state      <= precharge;
				end
				precharge: if (timer_done) begin
					ready <= 1'b1;
					state <= idle;
				end
				default: state <= idle;
			endcase
		end
	end

endmodule

// File: hw/sdram_pkg.sv
//===========================================================
// shared types for the SDR SDRAM controller: command codes,
// mode word, user request and registered pin bundle.
//===========================================================
package sdram_pkg;

	// {cs, ras, cas, we}, all active low.
	typedef enum logic [3:0] {
		nop          = 4'b0111,
		active       = 4'b0011,
		read         = 4'b0101,
		write        = 4'b0100,
		precharge    = 4'b0010,
		auto_refresh = 4'b0001,
		load_mode    = 4'b0000
	} sdram_cmd_e;

	// mode register layout, a[11] down to a[0].
	typedef struct packed {
		logic [1:0] rsv_hi;
		logic       wb_mode;  // write burst mode.
		logic [1:0] rsv_op;
		logic [2:0] cl;       // cas latency, 2 or 3.
		logic       bt;       // burst type, sequential only.
		logic [2:0] bl;       // 1, 2, 4, 8 as 0..3.
	} sdram_mode_t;

	// decoded fields, or the raw value put on addr by load_mode.
	typedef union packed {
		sdram_mode_t f;
		logic [11:0] raw;
	} sdram_mode_u;

	typedef struct packed {
		logic [1:0]  ba;
		logic [11:0] row;
		logic [7:0]  col;
	} sdram_req_t;

	// everything that leaves the chip on a clock edge.
	typedef struct packed {
		logic        cke;
		sdram_cmd_e  cmd;
		logic [1:0]  ba;
		logic [11:0] addr;
		logic [1:0]  dqm;
	} sdram_pins_t;

	// which wait the timer loads.
	typedef enum logic [2:0] {
		w_init,
		w_rp,
		w_rfc,
		w_mrd,
		w_rcd
	} sdram_wait_e;

endpackage

// File: hw/sdram_timer.sv
//===========================================================
// wait counter for the command spacing and the periodic
// refresh request. loaded by the controller FSM.
//===========================================================
`timescale 1ns/1ns
module sdram_timer #(
	parameter int CLK_MHZ = 143,
	parameter int INIT_US = 100
) (
	input  logic                   osc,
	input  logic                   rst_n,
	input  logic                   timer_load,
	input  sdram_pkg::sdram_wait_e timer_sel,
	output logic                   timer_done,
	output logic                   refresh_due,
	input  logic                   refresh_ack
);
	// cycles = ceil(ns * mhz / 1000) + 1.
	localparam int INIT_CYC = INIT_US * CLK_MHZ + 1;
	localparam int RP_CYC   = (20 * CLK_MHZ + 999) / 1000 + 1;
	localparam int RFC_CYC  = (63 * CLK_MHZ + 999) / 1000 + 1;
	localparam int MRD_CYC  = (30 * CLK_MHZ + 999) / 1000 + 1;
	localparam int RCD_CYC  = (20 * CLK_MHZ + 999) / 1000 + 1;
	localparam int REF_CYC  = 15625 * CLK_MHZ / 1000; // one row every 15.625 us.

	// power-up wait is the longest one.
	localparam int WW = $clog2(INIT_CYC);
	localparam int RW = $clog2(REF_CYC);

	logic [WW-1:0] cnt;
	logic [WW-1:0] load_val;
	logic [RW-1:0] ref_cnt;

	// load cycle and the registered command take two of the cycles.
	always_comb begin
		case (timer_sel)
			sdram_pkg::w_rp:  load_val = WW'(RP_CYC - 2);
			sdram_pkg::w_rfc: load_val = WW'(RFC_CYC - 2);
			sdram_pkg::w_mrd: load_val = WW'(MRD_CYC - 2);
			sdram_pkg::w_rcd: load_val = WW'(RCD_CYC - 2);
			default:          load_val = WW'(INIT_CYC - 2);
		endcase
	end

	// masked while a load is pending, so a stale zero is never seen.
	assign timer_done = (cnt == '0) && !timer_load;

	always_ff @(posedge osc) begin
		if (!rst_n) begin
			cnt <= '0;
		end else if (timer_load) begin
			cnt <= load_val;
		end else if (cnt != '0) begin
			cnt <= cnt - 1'b1;
		end
	end

	always_ff @(posedge osc) begin
		if (!rst_n) begin
			ref_cnt     <= RW'(REF_CYC - 1);
			refresh_due <= 1'b0;
		end else begin
			ref_cnt <= (ref_cnt == '0) ? RW'(REF_CYC - 1) : ref_cnt - 1'b1;
			if (refresh_ack)
				refresh_due <= 1'b0;
			if (ref_cnt == '0)
				refresh_due <= 1'b1; // held until the fsm takes it.
		end
	end

endmodule

// File: hw/sdram_top.sv
//===========================================================
// SDRAM controller top level. wires the FSM, timer and data
// path together; set CLK_MHZ and INIT_US here.
//===========================================================
`timescale 1ns/1ns
module sdram_top #(
	parameter int CLK_MHZ = 143,
	parameter int INIT_US = 100
) (
	input  logic                   osc,
	input  logic                   rst_n,
	input  sdram_pkg::sdram_mode_u mode,
	input  logic                   wr_req,
	input  logic                   rd_req,
	input  sdram_pkg::sdram_req_t  req,
	input  logic [15:0]            wr_data,
	output logic                   ready,
	output logic                   wr_next,
	output logic [15:0]            rd_data,
	output logic                   rd_valid,
	output sdram_pkg::sdram_pins_t pins,
	output logic                   sd_clk,
	inout  wire  [15:0]            dq
);
	logic                   timer_load;
	sdram_pkg::sdram_wait_e timer_sel;
	logic                   timer_done;
	logic                   refresh_due;
	logic                   refresh_ack;
	logic                   burst_wr;
	logic                   burst_rd;
	logic                   burst_end;

	assign sd_clk = osc; // part runs on the controller clock.

	sdram_fsm u_fsm (
		.osc(osc), .rst_n(rst_n), .mode(mode),
		.wr_req(wr_req), .rd_req(rd_req), .req(req),
		.ready(ready), .pins(pins),
		.timer_load(timer_load), .timer_sel(timer_sel), .timer_done(timer_done),
		.refresh_due(refresh_due), .refresh_ack(refresh_ack),
		.burst_wr(burst_wr), .burst_rd(burst_rd), .burst_end(burst_end)
	);

	sdram_timer #(.CLK_MHZ(CLK_MHZ), .INIT_US(INIT_US)) u_timer (
		.osc(osc), .rst_n(rst_n),
		.timer_load(timer_load), .timer_sel(timer_sel), .timer_done(timer_done),
		.refresh_due(refresh_due), .refresh_ack(refresh_ack)
	);

	sdram_datapath u_datapath (
		.osc(osc), .rst_n(rst_n), .mode(mode),
		.burst_wr(burst_wr), .burst_rd(burst_rd),
		.wr_data(wr_data), .wr_next(wr_next),
		.rd_data(rd_data), .rd_valid(rd_valid),
		.burst_end(burst_end), .dq(dq)
	);

endmodule

// File: sim/sdram_model.sv
//===========================================================
// behavioral SDR SDRAM for simulation. sparse array, burst
// wrap, cas-latency read return, refresh count, tRP/tRCD checks.
//===========================================================
`timescale 1ns/1ns
module sdram_model #(
	parameter int CLK_MHZ = 143
) (
	input  logic                   sd_clk,
	input  sdram_pkg::sdram_pins_t pins,
	inout  wire  [15:0]            dq,
	output logic                   viol
);
	localparam int T_RP  = (20 * CLK_MHZ + 999) / 1000; // spec minimum in cycles.
	localparam int T_RCD = (20 * CLK_MHZ + 999) / 1000;

	logic [15:0] mem [bit [21:0]];
	logic [15:0] cmd_log [$]; // {cmd, addr} of each command.
	int          ref_count = 0;
	logic [11:0] open_row [4];
	int          last_act [4];
	int          last_pre [4];
	int          cyc = 0;
	int          bl = 1;
	int          cl = 2;
	logic [1:0]  wr_ba;
	logic [7:0]  wr_col;
	int          wr_k = 0;
	int          wr_len = 0;
	logic        pipe_v [12];     // read words waiting to go out.
	logic [15:0] pipe_d [12];
	logic        drv_en;
	logic [15:0] drv_d;

	assign dq = drv_en ? drv_d : {16{1'bz}};

	initial begin
		viol   = 1'b0;
		drv_en = 1'b0;
		drv_d  = 16'h0000;
		for (int b = 0; b < 4; b++) begin
			last_act[b] = -100;
			last_pre[b] = -100;
		end
		for (int i = 0; i < 12; i++)
			pipe_v[i] = 1'b0;
	end

	// sequential wrap inside the aligned block.
	function automatic logic [21:0] word_addr(logic [1:0] ba, logic [7:0] col, int k);
		logic [7:0] mask;
		mask = 8'(bl - 1);
		return {ba, open_row[ba], (col & ~mask) | (8'(col + k) & mask)};
	endfunction

	function automatic logic [15:0] read_word(logic [21:0] a);
		if (mem.exists(a))
			return mem[a];
		return a[15:0] ^ {a[21:16], a[21:12]}; // never written.
	endfunction

	task automatic flag(string what);
		$display("SDRAM model error at %0t ns: %s", $time, what);
		viol <= 1'b1;
	endtask

	always @(posedge sd_clk) begin
		cyc = cyc + 1;
		if (pins.cke && pins.cmd != sdram_pkg::nop)
			cmd_log.push_back({pins.cmd, pins.addr});
		case (pins.cmd)
			sdram_pkg::active: begin
				if (cyc - last_pre[pins.ba] < T_RP)
					flag("active came too soon after precharge (tRP)");
				open_row[pins.ba] = pins.addr;
				last_act[pins.ba] = cyc;
			end
			sdram_pkg::precharge:
				for (int b = 0; b < 4; b++)
					if (pins.addr[10] || b == pins.ba)
						last_pre[b] = cyc;
			sdram_pkg::auto_refresh: begin
				for (int b = 0; b < 4; b++)
					if (cyc - last_pre[b] < T_RP)
						flag("auto refresh came too soon after precharge (tRP)");
				ref_count = ref_count + 1;
			end
			sdram_pkg::load_mode: begin
				bl = 1 << pins.addr[2:0];
				cl = pins.addr[6:4];
			end
			sdram_pkg::write: begin
				if (cyc - last_act[pins.ba] < T_RCD)
					flag("write came too soon after active (tRCD)");
				wr_ba  = pins.ba;
				wr_col = pins.addr[7:0];
				wr_len = bl;
				wr_k   = 0; // first word rides with the command.
			end
			sdram_pkg::read: begin
				if (cyc - last_act[pins.ba] < T_RCD)
					flag("read came too soon after active (tRCD)");
				for (int k = 0; k < bl; k++) begin
					pipe_v[cl - 1 + k] = 1'b1;
					pipe_d[cl - 1 + k] = read_word(word_addr(pins.ba, pins.addr[7:0], k));
				end
			end
			default: ;
		endcase
		if (wr_k < wr_len) begin
			if (pins.dqm != 2'b00)
				flag("a write data word was masked by dqm");
			mem[word_addr(wr_ba, wr_col, wr_k)] = dq;
			wr_k = wr_k + 1;
		end
		drv_en <= pipe_v[0];
		drv_d  <= pipe_d[0];
		for (int i = 0; i < 11; i++) begin
			pipe_v[i] = pipe_v[i + 1];
			pipe_d[i] = pipe_d[i + 1];
		end
		pipe_v[11] = 1'b0;
	end

endmodule

// File: sim/tb_sdram.sv
//===========================================================
// testbench for the SDRAM controller: init order, burst write
// and read back, cas latency, refresh and a random mix.
//===========================================================
`timescale 1ns/1ns
module tb_sdram;
	localparam int CLK_MHZ = 143;
	localparam int REF_CYC = 15625 * CLK_MHZ / 1000; // refresh interval in cycles.

	logic                   osc;
	logic                   rst_n;
	sdram_pkg::sdram_mode_u mode;
	logic                   wr_req;
	logic                   rd_req;
	sdram_pkg::sdram_req_t  req;
	logic [15:0]            wr_data;
	logic                   ready;
	logic                   wr_next;
	logic [15:0]            rd_data;
	logic                   rd_valid;
	sdram_pkg::sdram_pins_t pins;
	logic                   sd_clk;
	wire  [15:0]            dq;
	logic                   viol;

	integer                 seed = 32'h7559_ea34;
	int                     cur_bl = 1;
	int                     cur_cl = 2;
	logic [15:0]            shadow [bit [21:0]];
	sdram_pkg::sdram_req_t  written [$];

	sdram_top #(.CLK_MHZ(CLK_MHZ), .INIT_US(2)) dut (
		.osc(osc), .rst_n(rst_n), .mode(mode), .wr_req(wr_req), .rd_req(rd_req),
		.req(req), .wr_data(wr_data), .ready(ready), .wr_next(wr_next),
		.rd_data(rd_data), .rd_valid(rd_valid), .pins(pins), .sd_clk(sd_clk), .dq(dq)
	);

	sdram_model #(.CLK_MHZ(CLK_MHZ)) u_model (
		.sd_clk(sd_clk), .pins(pins), .dq(dq), .viol(viol)
	);

	initial begin
		osc = 1'b0;
		forever #2 osc = ~osc;
	end

	function automatic logic [15:0] expected_word(logic [1:0] ba, logic [11:0] row,
		logic [7:0] col);
		return shadow[{ba, row, col}];
	endfunction

	function automatic sdram_pkg::sdram_req_t random_req();
		sdram_pkg::sdram_req_t r;
		r.ba  = 2'($random(seed));
		r.row = 12'($random(seed));
		r.col = 8'($random(seed)) & ~8'(cur_bl - 1); // aligned to the burst.
		return r;
	endfunction

	task automatic abort_run(string why);
		$display("%s", why);
		$display("TEST RESULT: FAIL");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_equal(logic [31:0] got, logic [31:0] exp, string what);
		if (got !== exp)
			abort_run($sformatf("FAILED at %0t ns: %s, got %0h, expected %0h",
				$time, what, got, exp));
	endtask

	always @(posedge osc)
		if (viol === 1'b1)
			abort_run("the SDRAM model saw a command timing violation");

	task automatic wait_ready(int limit, string what);
		int n;
		n = 0;
		do begin
			@(posedge osc);
			n++;
			if (n > limit)
				abort_run($sformatf("timeout: %s never came", what));
		end while (!ready);
	endtask

	// strobe held until seen with ready high.
	task automatic issue(logic is_wr, sdram_pkg::sdram_req_t r);
		req    <= r;
		wr_req <= is_wr;
		rd_req <= !is_wr;
		wait_ready(400, "acceptance of a request");
		wr_req <= 1'b0;
		rd_req <= 1'b0;
	endtask

	task automatic write_burst(sdram_pkg::sdram_req_t r);
		logic [15:0] w [8];
		int k;
		int n;
		for (k = 0; k < cur_bl; k++) begin
			w[k] = 16'($random(seed));
			shadow[{r.ba, r.row, 8'(r.col + k)}] = w[k];
		end
		issue(1'b1, r);
		k = 0;
		n = 0;
		while (k < cur_bl) begin
			@(posedge osc);
			n++;
			if (wr_next) begin
				wr_data <= w[k];
				k++;
			end
			if (n > 100)
				abort_run("timeout: wr_next did not request all write words");
		end
		written.push_back(r);
	endtask

	task automatic read_burst(sdram_pkg::sdram_req_t r);
		int k;
		int n;
		int t_cmd;
		issue(1'b0, r);
		k = 0;
		n = 0;
		t_cmd = -1000;
		while (k < cur_bl) begin
			@(posedge osc);
			n++;
			if (pins.cmd == sdram_pkg::read)
				t_cmd = n;
			if (rd_valid) begin
				check_equal(n - t_cmd, cur_cl + 1 + k, "cycles from read command to rd_valid");
				check_equal(rd_data, expected_word(r.ba, r.row, 8'(r.col + k)), "read data");
				k++;
			end
			if (n > 100)
				abort_run("timeout: rd_valid did not deliver the whole read burst");
		end
	endtask

	task automatic power_up(int cl, int blc);
		int start;
		logic [15:0] e [4];
		rst_n  <= 1'b0;
		mode   <= {2'b00, 1'b0, 2'b00, 3'(cl), 1'b0, 3'(blc)};
		cur_cl = cl;
		cur_bl = 1 << blc;
		repeat (10) @(posedge osc);
		start = u_model.cmd_log.size();
		rst_n <= 1'b1;
		wait_ready(2000, "ready after initialization");
		check_equal(u_model.cmd_log.size() - start, 4, "commands before ready");
		for (int i = 0; i < 4; i++)
			e[i] = u_model.cmd_log[start + i];
		check_equal(e[0][15:12], sdram_pkg::precharge, "first init command");
		check_equal(e[0][10], 1'b1, "precharge all bit");
		check_equal(e[1][15:12], sdram_pkg::auto_refresh, "second init command");
		check_equal(e[2][15:12], sdram_pkg::auto_refresh, "third init command");
		check_equal(e[3][15:12], sdram_pkg::load_mode, "fourth init command");
		check_equal(e[3][11:0], mode.raw, "mode word on addr");
		written.delete();
	endtask

	initial begin
		int n0;
		int waited;
		sdram_pkg::sdram_req_t r;
		rst_n   = 1'b0;
		wr_req  = 1'b0;
		rd_req  = 1'b0;
		req     = '0;
		wr_data = 16'h0000;
		mode    = '0;
		for (int c = 2; c <= 3; c++)
			for (int b = 0; b < 4; b++) begin
				power_up(c, b);
				repeat (4) begin
					r = random_req();
					write_burst(r);
					read_burst(r);
				end
			end
		// long idle stretch with cl 3 and bl 8 still loaded.
		@(negedge osc);
		n0 = u_model.ref_count;
		repeat (5 * REF_CYC + 100) @(negedge osc);
		check_equal(u_model.ref_count - n0 >= 5, 1'b1, "auto refreshes over five intervals");
		waited = 0;
		do begin
			@(posedge osc);
			waited++;
			if (waited > REF_CYC + 100)
				abort_run("timeout: no refresh precharge came while idle");
		end while (!(pins.cmd == sdram_pkg::precharge && pins.addr[10]));
		r = random_req();
		write_burst(r); // waits out the refresh.
		read_burst(r);
		power_up(3, 2);
		for (int i = 0; i < 300; i++) begin
			if (written.size() == 0 || ($random(seed) & 1)) begin
				write_burst(random_req());
			end else begin
				r = written[$unsigned($random(seed)) % written.size()];
				read_burst(r);
			end
		end
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule
